/* src/srtDiv_defs.svh */
`ifndef SRTDIV_DEFS_SVH
`define SRTDIV_DEFS_SVH

// operand and quotient width
`define DIV_WIDTH 32

// write-back register address
`define TAG_WIDTH 5

// partial remainder with sign bit and room for twice the divisor
`define REM_WIDTH (`DIV_WIDTH + 3)

// leading-zero count, 0 to 32
`define SHIFT_WIDTH 6

// iteration counter, 1 to 17
`define ITER_WIDTH 5

// selection table inputs
`define SEL_DIVISOR_BITS 4
`define SEL_REM_BITS 6

`endif

/* src/srtDivPkg.sv */
`include "srtDiv_defs.svh"

package srtDivPkg;

    // radix-4 digit set, two's complement coded
    typedef enum logic [2:0] {
        qZero = 3'b000,
        qPos1 = 3'b001,
        qPos2 = 3'b010,
        qNeg2 = 3'b110,
        qNeg1 = 3'b111
    } quoDigitE;

    typedef struct packed {
        logic                    isSigned;
        logic [`DIV_WIDTH-1:0]   dividend;
        logic [`DIV_WIDTH-1:0]   divisor;
        logic [`TAG_WIDTH-1:0]   tag;
    } divReqT;

    typedef struct packed {
        logic [`DIV_WIDTH-1:0]   quotient;
        logic [`TAG_WIDTH-1:0]   tag;
    } divRespT;

    typedef struct packed {
        logic [`REM_WIDTH-1:0]   remInit;
        logic [`DIV_WIDTH-1:0]   divisorNorm;
        logic [`ITER_WIDTH-1:0]  iterCount;
        logic                    negQuot;
        logic                    divByZero;
        logic [`TAG_WIDTH-1:0]   tag;
    } prepT;

endpackage

/* src/divOperandPrep.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module divOperandPrep import srtDivPkg::*; (
    input  divReqT req,
    output prepT   prep
);

    logic                     dividendNeg;
    logic                     divisorNeg;
    logic [`DIV_WIDTH-1:0]    dividendMag;
    logic [`DIV_WIDTH-1:0]    divisorMag;
    logic [7:0]               grpZero;
    logic [1:0]               grpLz [8];
    logic [`SHIFT_WIDTH-1:0]  lzCount;
    logic [`SHIFT_WIDTH-1:0]  iterWide;

    assign dividendNeg = req.isSigned & req.dividend[`DIV_WIDTH-1];
    assign divisorNeg  = req.isSigned & req.divisor[`DIV_WIDTH-1];

    // most negative value maps onto 2^31 unsigned
    assign dividendMag = dividendNeg ? -req.dividend : req.dividend;
    assign divisorMag  = divisorNeg ? -req.divisor : req.divisor;

    // per-nibble zero flag and leading zeros, group 0 is the top nibble
    always_comb begin
        logic [3:0] nib;
        for (int g = 0; g < 8; g++) begin
            nib = divisorMag[`DIV_WIDTH-1-4*g -: 4];
            grpZero[g] = (nib == 4'b0000);
            if (nib[3]) begin
                grpLz[g] = 2'd0;
            end else if (nib[2]) begin
                grpLz[g] = 2'd1;
            end else if (nib[1]) begin
                grpLz[g] = 2'd2;
            end else begin
                grpLz[g] = 2'd3;
            end
        end
    end

    // priority encode, topmost nonzero group wins
    always_comb begin
        lzCount = `SHIFT_WIDTH'(32);
        for (int g = 7; g >= 0; g--) begin
            if (!grpZero[g]) begin
                lzCount = {1'b0, 3'(g), 2'b00} + {4'b0000, grpLz[g]};
            end
        end
    end

    // odd counts take one digit more, so the dividend sits one bit lower
    assign iterWide = ((lzCount + `SHIFT_WIDTH'(1)) >> 1) + `SHIFT_WIDTH'(1);

    assign prep.remInit     = lzCount[0] ? {3'b000, dividendMag} : {2'b00, dividendMag, 1'b0};
    assign prep.divisorNorm = divisorMag << lzCount;
    assign prep.iterCount   = iterWide[`ITER_WIDTH-1:0];
    assign prep.negQuot     = dividendNeg ^ divisorNeg;
    assign prep.divByZero   = (req.divisor == '0);
    assign prep.tag         = req.tag;

endmodule

/* src/quotientSelect.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module quotientSelect import srtDivPkg::*; (
    input  logic        [`SEL_DIVISOR_BITS-1:0] divisorTop,
    input  logic signed [`SEL_REM_BITS-1:0]     remTop,
    output quoDigitE                            digit
);

    logic signed [`SEL_REM_BITS-1:0] thr2;
    logic signed [`SEL_REM_BITS-1:0] thr1;
    logic signed [`SEL_REM_BITS-1:0] thr0;
    logic signed [`SEL_REM_BITS-1:0] thrN1;
    logic                            inRange;

    // thresholds on 4w in sixteenths, one row per divisor interval
    always_comb begin
        inRange = 1'b1;
        case (divisorTop)
            4'b1000: begin
                thr2 = 12; thr1 = 4; thr0 = -4; thrN1 = -13;
            end
            4'b1001: begin
                thr2 = 14; thr1 = 4; thr0 = -6; thrN1 = -15;
            end
            4'b1010: begin
                thr2 = 15; thr1 = 4; thr0 = -6; thrN1 = -16;
            end
            4'b1011: begin
                thr2 = 16; thr1 = 4; thr0 = -6; thrN1 = -18;
            end
            4'b1100: begin
                thr2 = 18; thr1 = 6; thr0 = -8; thrN1 = -20;
            end
            4'b1101: begin
                thr2 = 20; thr1 = 6; thr0 = -8; thrN1 = -20;
            end
            4'b1110: begin
                thr2 = 20; thr1 = 8; thr0 = -8; thrN1 = -22;
            end
            4'b1111: begin
                thr2 = 24; thr1 = 8; thr0 = -8; thrN1 = -24;
            end
            default: begin
                // unnormalized divisor, only seen on divide by zero
                thr2 = 0; thr1 = 0; thr0 = 0; thrN1 = 0;
                inRange = 1'b0;
            end
        endcase
    end

    always_comb begin
        if (!inRange) begin
            digit = qZero;
        end else if (remTop >= thr2) begin
            digit = qPos2;
        end else if (remTop >= thr1) begin
            digit = qPos1;
        end else if (remTop >= thr0) begin
            digit = qZero;
        end else if (remTop >= thrN1) begin
            digit = qNeg1;
        end else begin
            digit = qNeg2;
        end
    end

endmodule

/* src/divIterControl.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module divIterControl import srtDivPkg::*; (
    input  logic                               Clk,
    input  logic                               arstN,
    input  logic                               start,
    input  prepT                               prep,
    input  quoDigitE                           digit,
    output logic                               ready,
    output logic        [`SEL_DIVISOR_BITS-1:0] divisorTop,
    output logic signed [`SEL_REM_BITS-1:0]     remTop,
    output logic                               digitValid,
    output logic                               convClear,
    output logic                               finish,
    output logic                               remNegative,
    output logic                               negQuot,
    output logic                               divByZero,
    output logic        [`TAG_WIDTH-1:0]       tag
);

    typedef enum logic [1:0] {
        sIdle   = 2'd0,
        sIter   = 2'd1,
        sFinish = 2'd2
    } stateE;

    stateE                    state;
    logic [`ITER_WIDTH-1:0]   iterCnt;
    logic                     firstIter;
    logic [`REM_WIDTH-1:0]    remReg;
    logic [`DIV_WIDTH-1:0]    divisorReg;
    logic [`REM_WIDTH:0]      remShifted;
    logic [`REM_WIDTH:0]      divisorX2;
    logic [`REM_WIDTH:0]      divisorX4;
    logic [`REM_WIDTH:0]      remNext;

    // first step uses the loaded dividend as 4w directly
    assign remShifted = firstIter ? {remReg[`REM_WIDTH-1], remReg}
                                  : {remReg[`REM_WIDTH-2:0], 2'b00};

    // divisor sits one bit up in the remainder frame
    assign divisorX2 = {3'b000, divisorReg, 1'b0};
    assign divisorX4 = {2'b00, divisorReg, 2'b00};

    always_comb begin
        case (digit)
            qPos2:   remNext = remShifted - divisorX4;
            qPos1:   remNext = remShifted - divisorX2;
            qNeg1:   remNext = remShifted + divisorX2;
            qNeg2:   remNext = remShifted + divisorX4;
            default: remNext = remShifted;
        endcase
    end

    // estimate saturates, anything beyond +-2 picks a full digit anyway
    always_comb begin
        case (remShifted[`REM_WIDTH -: 2])
            2'b01:   remTop = 6'sb011111;
            2'b10:   remTop = 6'sb100000;
            default: remTop = remShifted[`REM_WIDTH-1 -: `SEL_REM_BITS];
        endcase
    end

    assign divisorTop  = divisorReg[`DIV_WIDTH-1 -: `SEL_DIVISOR_BITS];
    assign ready       = (state == sIdle);
    assign digitValid  = (state == sIter);
    assign finish      = (state == sFinish);
    assign convClear   = start & (state == sIdle);
    assign remNegative = remReg[`REM_WIDTH-1];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state     <= sIdle;
            iterCnt   <= '0;
            firstIter <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (start) begin
                        state     <= sIter;
                        iterCnt   <= prep.iterCount;
                        firstIter <= 1'b1;
                    end
                end
                sIter: begin
                    firstIter <= 1'b0;
                    iterCnt   <= iterCnt - 1'b1;
                    if (iterCnt == `ITER_WIDTH'(1)) begin
                        state <= sFinish;
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    // held operands and partial remainder
    always_ff @(posedge Clk) begin
        if (start && state == sIdle) begin
            remReg     <= prep.remInit;
            divisorReg <= prep.divisorNorm;
            negQuot    <= prep.negQuot;
            divByZero  <= prep.divByZero;
            tag        <= prep.tag;
        end else if (state == sIter) begin
            remReg <= remNext[`REM_WIDTH-1:0];
        end
    end

    startOnlyWhenIdle: assert property (
        @(posedge Clk) disable iff (!arstN) start |-> state == sIdle);

    // selection table is only valid for a normalized divisor
    divisorNormalized: assert property (
        @(posedge Clk) disable iff (!arstN)
        (state == sIter && !divByZero) |-> divisorReg[`DIV_WIDTH-1]);

endmodule

/* src/onTheFlyConvert.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module onTheFlyConvert import srtDivPkg::*; (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   convClear,
    input  logic                   digitValid,
    input  quoDigitE               digit,
    output logic [`DIV_WIDTH-1:0]  quot,
    output logic [`DIV_WIDTH-1:0]  quotMinus
);

    logic [`DIV_WIDTH-3:0] qLow;
    logic [`DIV_WIDTH-3:0] qmLow;

    assign qLow  = quot[`DIV_WIDTH-3:0];
    assign qmLow = quotMinus[`DIV_WIDTH-3:0];

    // quotMinus tracks quot minus one, so it starts at all ones
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            quot      <= '0;
            quotMinus <= '1;
        end else if (convClear) begin
            quot      <= '0;
            quotMinus <= '1;
        end else if (digitValid) begin
            case (digit)
                qPos2: begin
                    quot      <= {qLow, 2'b10};
                    quotMinus <= {qLow, 2'b01};
                end
                qPos1: begin
                    quot      <= {qLow, 2'b01};
                    quotMinus <= {qLow, 2'b00};
                end
                qNeg1: begin
                    quot      <= {qmLow, 2'b11};
                    quotMinus <= {qmLow, 2'b10};
                end
                qNeg2: begin
                    quot      <= {qmLow, 2'b10};
                    quotMinus <= {qmLow, 2'b01};
                end
                default: begin
                    quot      <= {qLow, 2'b00};
                    quotMinus <= {qmLow, 2'b11};
                end
            endcase
        end
    end

    digitLegal: assert property (
        @(posedge Clk) disable iff (!arstN)
        digitValid |-> digit inside {qPos2, qPos1, qZero, qNeg1, qNeg2});

endmodule

/* src/resultFixup.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module resultFixup import srtDivPkg::*; (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   finish,
    input  logic                   remNegative,
    input  logic                   negQuot,
    input  logic                   divByZero,
    input  logic [`TAG_WIDTH-1:0]  tag,
    input  logic [`DIV_WIDTH-1:0]  quot,
    input  logic [`DIV_WIDTH-1:0]  quotMinus,
    output logic                   done,
    output divRespT                resp
);

    logic [`DIV_WIDTH-1:0] quotCorr;
    logic [`DIV_WIDTH-1:0] quotSigned;
    logic [`DIV_WIDTH-1:0] quotFinal;

    // negative last remainder means one digit too many was taken
    assign quotCorr   = remNegative ? quotMinus : quot;
    assign quotSigned = negQuot ? -quotCorr : quotCorr;

    // divide by zero returns all ones, no trap
    assign quotFinal  = divByZero ? '1 : quotSigned;

    always_ff @(posedge Clk) begin
        if (finish) begin
            resp.quotient <= quotFinal;
            resp.tag      <= tag;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

endmodule

/* src/srtDivider.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module srtDivider import srtDivPkg::*; (
    input  logic    Clk,
    input  logic    arstN,
    input  logic    start,
    input  divReqT  req,
    output logic    ready,
    output logic    done,
    output divRespT resp
);

    prepT                               prep;
    quoDigitE                           digit;
    logic        [`SEL_DIVISOR_BITS-1:0] divisorTop;
    logic signed [`SEL_REM_BITS-1:0]     remTop;
    logic                               digitValid;
    logic                               convClear;
    logic                               finish;
    logic                               remNegative;
    logic                               negQuot;
    logic                               divByZero;
    logic        [`TAG_WIDTH-1:0]       tag;
    logic        [`DIV_WIDTH-1:0]       quot;
    logic        [`DIV_WIDTH-1:0]       quotMinus;

    divOperandPrep u_divOperandPrep (
        .req  (req),
        .prep (prep)
    );

    divIterControl u_divIterControl (
        .Clk         (Clk),
        .arstN       (arstN),
        .start       (start),
        .prep        (prep),
        .digit       (digit),
        .ready       (ready),
        .divisorTop  (divisorTop),
        .remTop      (remTop),
        .digitValid  (digitValid),
        .convClear   (convClear),
        .finish      (finish),
        .remNegative (remNegative),
        .negQuot     (negQuot),
        .divByZero   (divByZero),
        .tag         (tag)
    );

    quotientSelect u_quotientSelect (
        .divisorTop (divisorTop),
        .remTop     (remTop),
        .digit      (digit)
    );

    onTheFlyConvert u_onTheFlyConvert (
        .Clk        (Clk),
        .arstN      (arstN),
        .convClear  (convClear),
        .digitValid (digitValid),
        .digit      (digit),
        .quot       (quot),
        .quotMinus  (quotMinus)
    );

    resultFixup u_resultFixup (
        .Clk         (Clk),
        .arstN       (arstN),
        .finish      (finish),
        .remNegative (remNegative),
        .negQuot     (negQuot),
        .divByZero   (divByZero),
        .tag         (tag),
        .quot        (quot),
        .quotMinus   (quotMinus),
        .done        (done),
        .resp        (resp)
    );

endmodule

/* verif/srtDividerTb.sv */
`timescale 1ns/1ps
`include "srtDiv_defs.svh"

module srtDividerTb import srtDivPkg::*; ();

    localparam int NUM_REQ        = 400;
    localparam int MAX_LATENCY    = 19;
    localparam int MAX_GAP        = 3;
    localparam int TIMEOUT_CYCLES = NUM_REQ * (MAX_LATENCY + MAX_GAP) + 100;

    logic    Clk;
    logic    arstN;
    logic    start;
    divReqT  req;
    logic    ready;
    logic    done;
    divRespT resp;
    int      cycleCnt;

    srtDivider u_srtDivider (
        .Clk   (Clk),
        .arstN (arstN),
        .start (start),
        .req   (req),
        .ready (ready),
        .done  (done),
        .resp  (resp)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // run limit in clock cycles
    initial begin
        cycleCnt = 0;
        forever begin
            @(posedge Clk);
            cycleCnt++;
            if (cycleCnt >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles, divider stopped responding", cycleCnt);
                $display("ERRORS FOUND");
                $fatal(1, "run stopped by timeout");
            end
        end
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    // quotient from the integer operators with truncation toward zero
    function automatic logic [`DIV_WIDTH-1:0] modelQuotient(input divReqT r);
        logic signed [`DIV_WIDTH-1:0] sDividend;
        logic signed [`DIV_WIDTH-1:0] sDivisor;
        logic signed [`DIV_WIDTH-1:0] sQuot;
        sDividend = r.dividend;
        sDivisor  = r.divisor;
        if (r.divisor == '0) begin
            return '1;
        end
        if (r.isSigned) begin
            // overflow case wraps back onto the most negative value
            if (r.dividend == 32'h8000_0000 && r.divisor == 32'hFFFF_FFFF) begin
                return 32'h8000_0000;
            end
            sQuot = sDividend / sDivisor;
            return sQuot;
        end
        return r.dividend / r.divisor;
    endfunction

    // random value with its top set bit at position w-1 or zero when w is 0
    function automatic logic [`DIV_WIDTH-1:0] randOfWidth(input int w);
        logic [`DIV_WIDTH-1:0] v;
        v = $urandom;
        if (w == 0) begin
            return '0;
        end
        if (w < `DIV_WIDTH) begin
            v = v & ((32'h1 << w) - 32'h1);
        end
        v[w-1] = 1'b1;
        return v;
    endfunction

    function automatic divReqT makeReq(input logic isSigned, input logic [31:0] dividend,
                                       input logic [31:0] divisor, input int tag);
        divReqT r;
        r.isSigned = isSigned;
        r.dividend = dividend;
        r.divisor  = divisor;
        r.tag      = tag[`TAG_WIDTH-1:0];
        return r;
    endfunction

    // divisor width walks through 0 to 32 so every iteration count shows up
    function automatic divReqT randomReq(input int idx);
        divReqT r;
        r.isSigned = 1'($urandom % 2);
        r.divisor  = randOfWidth(idx % 33);
        r.dividend = randOfWidth($urandom % 33);
        if (r.isSigned && ($urandom % 2)) begin
            r.divisor = -r.divisor;
        end
        if (r.isSigned && ($urandom % 2)) begin
            r.dividend = -r.dividend;
        end
        r.tag = `TAG_WIDTH'($urandom);
        return r;
    endfunction

    // one request from the idle negedge through the done pulse
    task automatic runRequest(input divReqT r);
        logic [`DIV_WIDTH-1:0] expQuot;
        int                    cycles;
        expQuot = modelQuotient(r);
        assert (ready) else failRun("ready is low while the divider should be idle");
        @(posedge Clk);
        start <= 1'b1;
        req   <= r;
        @(posedge Clk);
        start <= 1'b0;
        cycles = 1;
        @(negedge Clk);
        while (!done) begin
            assert (!ready) else failRun("ready went high before done");
            assert (cycles < MAX_LATENCY) else failRun("no done pulse within 19 cycles");
            @(negedge Clk);
            cycles++;
        end
        assert (ready) else failRun("ready is not high together with done");
        assert (resp.quotient == expQuot) else
            failRun($sformatf("Fail at %0t: resp.quotient = %h, expected %h",
                              $time, resp.quotient, expQuot));
        assert (resp.tag == r.tag) else
            failRun($sformatf("Fail at %0t: resp.tag = %h, expected %h",
                              $time, resp.tag, r.tag));
        @(negedge Clk);
        assert (!done) else failRun("done stayed high for more than one cycle");
    endtask

    initial begin
        divReqT directed [$];
        divReqT r;
        int     gap;
        void'($urandom(32'h74225480));
        arstN = 1'b0;
        start = 1'b0;
        req   = '0;

        repeat (3) @(posedge Clk);
        arstN <= 1'b1;
        @(negedge Clk);
        assert (ready && !done) else failRun("ready low or done high after reset");

        // sign combinations, overflow and zero divisors
        directed.push_back(makeReq(1'b1, 32'h8000_0000, 32'hFFFF_FFFF, 1));
        directed.push_back(makeReq(1'b1, 32'h8000_0000, 32'h0000_0001, 2));
        directed.push_back(makeReq(1'b1, -32'sd7, 32'd2, 3));
        directed.push_back(makeReq(1'b1, 32'd7, -32'sd2, 4));
        directed.push_back(makeReq(1'b1, -32'sd7, -32'sd2, 5));
        directed.push_back(makeReq(1'b0, 32'd100, 32'd0, 6));
        directed.push_back(makeReq(1'b1, -32'sd5, 32'd0, 7));
        directed.push_back(makeReq(1'b0, 32'hFFFF_FFFF, 32'h0000_0001, 8));

        for (int i = 0; i < NUM_REQ; i++) begin
            if (i < directed.size()) begin
                r = directed[i];
            end else begin
                r = randomReq(i);
            end
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) begin
                @(negedge Clk);
                assert (!done) else failRun("done pulse with no request in flight");
            end
            runRequest(r);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/srtDivPkg.sv
src/divOperandPrep.sv
src/quotientSelect.sv
src/divIterControl.sv
src/onTheFlyConvert.sv
src/resultFixup.sv
src/srtDivider.sv
verif/srtDividerTb.sv

/* Bender.yml */
package:
  name: srtDivider

export_include_dirs:
  - src

sources:
  - src/srtDivPkg.sv
  - src/divOperandPrep.sv
  - src/quotientSelect.sv
  - src/divIterControl.sv
  - src/onTheFlyConvert.sv
  - src/resultFixup.sv
  - src/srtDivider.sv
  - target: test
    files:
      - verif/srtDividerTb.sv
